// ==== logic/inv_rms_unit.sv ====
/*
 * Inverse RMS. Mean square by shift, bitwise floor square root, then a
 * restoring division of 2^RECIP_FRAC by the root
 */
module inv_rms_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  logic [rms_norm_pkg::SUM_W-1:0] sum,
  input  rms_norm_pkg::shift_t           k_shift,
  output logic [rms_norm_pkg::INV_W-1:0] inv_rms,
  output logic                           inv_valid
);

  import rms_norm_pkg::*;

  localparam int RAD_W = 2 * ROOT_W;
  localparam int REM_W = ROOT_W + 3;
  localparam int CNT_W = $clog2(INV_W);

  typedef enum logic [1:0] {ST_IDLE, ST_SQRT, ST_DIV, ST_FIN} state_t;

  state_t            state;
  logic [CNT_W-1:0]  step;
  logic [RAD_W-1:0]  rad;
  logic [REM_W-1:0]  rem;
  logic [ROOT_W-1:0] root;
  logic [ROOT_W-1:0] drem;
  logic [INV_W-1:0]  quo;
  logic [REM_W-1:0]  rem_sh;
  logic [REM_W-1:0]  trial;
  logic              sq_bit;
  logic [ROOT_W:0]   drem_sh;
  logic              dv_bit;

  // -------------------------------------------------------------------------
  // One root bit and one quotient bit per cycle
  // -------------------------------------------------------------------------
  always_comb begin
    rem_sh  = {rem[REM_W-3:0], rad[RAD_W-1 -: 2]};
    trial   = {1'b0, root, 2'b01};
    sq_bit  = (rem_sh >= trial);
    // Dividend bits leave the top of quo as quotient bits enter below
    drem_sh = {drem, quo[INV_W-1]};
    dv_bit  = (drem_sh >= {1'b0, root});
  end

  // -------------------------------------------------------------------------
  // Sequencing, ROOT_W + INV_W + 2 cycles from start to inv_valid
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      step      <= '0;
      inv_valid <= 1'b0;
    end else begin
      inv_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_SQRT;
            step  <= '0;
          end
        end
        ST_SQRT: begin
          if (step == CNT_W'(ROOT_W - 1)) begin
            state <= ST_DIV;
            step  <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        ST_DIV: begin
          if (step == CNT_W'(INV_W - 1)) begin
            state <= ST_FIN;
          end else begin
            step <= step + 1'b1;
          end
        end
        ST_FIN: begin
          state     <= ST_IDLE;
          inv_valid <= 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      ST_IDLE: begin
        if (start) begin
          rad  <= RAD_W'(sum >> k_shift);
          rem  <= '0;
          root <= '0;
        end
      end
      ST_SQRT: begin
        rad  <= rad << 2;
        rem  <= sq_bit ? rem_sh - trial : rem_sh;
        root <= {root[ROOT_W-2:0], sq_bit};
        drem <= '0;
        quo  <= INV_W'(1) << RECIP_FRAC;
      end
      ST_DIV: begin
        // A zero root sets every quotient bit, giving 8191
        drem <= dv_bit ? ROOT_W'(drem_sh - {1'b0, root}) : drem_sh[ROOT_W-1:0];
        quo  <= {quo[INV_W-2:0], dv_bit};
      end
      ST_FIN: inv_rms <= quo;
      default: ;
    endcase
  end

endmodule

// ==== logic/norm_scale_pipe.sv ====
/*
 * Two-stage lane pipeline. x * gamma first, then times inv_rms,
 * arithmetic shift right and int8 saturation
 */
module norm_scale_pipe #(
  parameter int BUS_NUM = rms_norm_pkg::BUS_NUM
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              in_valid,
  input  rms_norm_pkg::elem_t [BUS_NUM-1:0] x_beat,
  input  rms_norm_pkg::elem_t [BUS_NUM-1:0] gamma_beat,
  input  logic                              beat_last,
  input  logic [rms_norm_pkg::INV_W-1:0]    inv_rms,
  input  rms_norm_pkg::shift_t              out_shift,
  input  logic                              out_ready,
  output logic                              in_ready,
  output logic                              out_valid,
  output rms_norm_pkg::elem_t [BUS_NUM-1:0] out_data,
  output logic                              out_last
);

  import rms_norm_pkg::*;

  localparam int PROD_W = 16;
  localparam int SCL_W  = PROD_W + INV_W + 1;

  logic signed [PROD_W-1:0] s1_prod [BUS_NUM];
  logic                     s1_valid;
  logic                     s1_last;
  logic                     s1_en;
  logic                     s2_en;
  elem_t [BUS_NUM-1:0]      sat_data;

  // Each stage moves when the one after it is empty or draining
  assign s2_en    = !out_valid || out_ready;
  assign s1_en    = !s1_valid || s2_en;
  assign in_ready = s1_en;

  // Stage 1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
    end else if (s1_en) begin
      s1_valid <= in_valid;
      s1_last  <= in_valid && beat_last;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_en && in_valid) begin
      for (int i = 0; i < BUS_NUM; i++) begin
        s1_prod[i] <= x_beat[i] * gamma_beat[i];
      end
    end
  end

  // Stage 2 arithmetic, >>> floors toward minus infinity
  always_comb begin
    logic signed [SCL_W-1:0] scaled;
    for (int i = 0; i < BUS_NUM; i++) begin
      scaled = s1_prod[i] * $signed({1'b0, inv_rms});
      scaled = scaled >>> out_shift;
      if (scaled > 127) begin
        sat_data[i] = 8'sd127;
      end else if (scaled < -128) begin
        sat_data[i] = -8'sd128;
      end else begin
        sat_data[i] = scaled[7:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (s2_en) begin
      out_valid <= s1_valid;
      out_last  <= s1_valid && s1_last;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_en && s1_valid) begin
      out_data <= sat_data;
    end
  end

endmodule

// ==== logic/rms_norm.sv ====
/*
 * RMS normalisation engine for int8 vectors on parallel lanes,
 * valid/ready on input and output
 */
module rms_norm #(
  parameter int BUS_NUM = rms_norm_pkg::BUS_NUM
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cfg_valid,
  input  logic [rms_norm_pkg::LEN_W-1:0]    cfg_len,
  input  rms_norm_pkg::shift_t              cfg_k_shift,
  input  rms_norm_pkg::shift_t              cfg_out_shift,
  input  logic                              in_valid,
  output logic                              in_ready,
  input  rms_norm_pkg::elem_t [BUS_NUM-1:0] in_data,
  input  rms_norm_pkg::elem_t [BUS_NUM-1:0] in_gamma,
  output logic                              out_valid,
  input  logic                              out_ready,
  output rms_norm_pkg::elem_t [BUS_NUM-1:0] out_data,
  output logic                              out_last
);

  import rms_norm_pkg::*;

  logic                         accept;
  logic                         start;
  shift_t                       k_shift;
  shift_t                       out_shift;
  logic                         rd_en;
  logic [$clog2(MAX_BEATS)-1:0] rd_addr;
  logic                         rd_last;
  logic                         rd_fire;
  logic                         rd_valid;
  logic                         pipe_ready;
  logic                         beat_last;
  elem_t [BUS_NUM-1:0]          x_beat;
  elem_t [BUS_NUM-1:0]          gamma_beat;
  logic [SUM_W-1:0]             sum;
  logic [INV_W-1:0]             inv_rms;
  logic                         inv_valid;
  logic                         out_fire;

  assign out_fire = out_valid && out_ready;

  // -------------------------------------------------------------------------
  // Sequencing and configuration
  // -------------------------------------------------------------------------
  rms_norm_ctrl ctrl_i (
    .clk(clk), .rst_n(rst_n),
    .cfg_valid(cfg_valid), .cfg_len(cfg_len),
    .cfg_k_shift(cfg_k_shift), .cfg_out_shift(cfg_out_shift),
    .in_valid(in_valid), .inv_valid(inv_valid),
    .rd_fire(rd_fire), .out_fire(out_fire),
    .in_ready(in_ready), .accept(accept), .vec_done(), .start(start),
    .k_shift(k_shift), .out_shift(out_shift),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_last(rd_last)
  );

  square_sum_acc acc_i (
    .clk(clk), .rst_n(rst_n),
    .accept(accept), .in_data(in_data),
    .clear(start), .sum(sum)
  );

  inv_rms_unit inv_i (
    .clk(clk), .rst_n(rst_n),
    .start(start), .sum(sum), .k_shift(k_shift),
    .inv_rms(inv_rms), .inv_valid(inv_valid)
  );

  // -------------------------------------------------------------------------
  // Beat store and output datapath
  // -------------------------------------------------------------------------
  vector_buffer #(.BUS_NUM(BUS_NUM)) buf_i (
    .clk(clk), .rst_n(rst_n),
    .accept(accept), .in_data(in_data), .in_gamma(in_gamma),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_last(rd_last),
    .pipe_ready(pipe_ready), .rd_valid(rd_valid),
    .x_beat(x_beat), .gamma_beat(gamma_beat),
    .beat_last(beat_last), .rd_fire(rd_fire)
  );

  norm_scale_pipe #(.BUS_NUM(BUS_NUM)) pipe_i (
    .clk(clk), .rst_n(rst_n),
    .in_valid(rd_valid), .x_beat(x_beat), .gamma_beat(gamma_beat),
    .beat_last(beat_last), .inv_rms(inv_rms), .out_shift(out_shift),
    .out_ready(out_ready), .in_ready(pipe_ready),
    .out_valid(out_valid), .out_data(out_data), .out_last(out_last)
  );

endmodule

// ==== logic/rms_norm_ctrl.sv ====
/*
 * Engine sequencer. Holds the configuration, steps each vector through
 * load, compute and replay, and addresses the buffer for replay
 */
module rms_norm_ctrl (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       cfg_valid,
  input  logic [rms_norm_pkg::LEN_W-1:0]             cfg_len,
  input  rms_norm_pkg::shift_t                       cfg_k_shift,
  input  rms_norm_pkg::shift_t                       cfg_out_shift,
  input  logic                                       in_valid,
  input  logic                                       inv_valid,
  input  logic                                       rd_fire,
  input  logic                                       out_fire,
  output logic                                       in_ready,
  output logic                                       accept,
  output logic                                       vec_done,
  output logic                                       start,
  output rms_norm_pkg::shift_t                       k_shift,
  output rms_norm_pkg::shift_t                       out_shift,
  output logic                                       rd_en,
  output logic [$clog2(rms_norm_pkg::MAX_BEATS)-1:0] rd_addr,
  output logic                                       rd_last
);

  import rms_norm_pkg::*;

  typedef enum logic [1:0] {PH_LOAD, PH_COMPUTE, PH_REPLAY} phase_t;

  phase_t           phase;
  logic [LEN_W-1:0] len_beats;
  logic [LEN_W-1:0] last_beat;
  logic [LEN_W-1:0] beat_cnt;
  logic [LEN_W-1:0] out_cnt;
  logic             rd_done;
  logic             cfg_open;

  assign last_beat = len_beats - 1'b1;
  assign in_ready  = (phase == PH_LOAD);
  assign accept    = in_valid && in_ready;
  assign vec_done  = accept && (beat_cnt == last_beat);
  // Config only lands before the first beat of a vector
  assign cfg_open  = in_ready && (beat_cnt == '0);
  assign rd_en     = (phase == PH_REPLAY) && !rd_done;
  assign rd_last   = (LEN_W'(rd_addr) == last_beat);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      len_beats <= LEN_W'(1);
      k_shift   <= '0;
      out_shift <= '0;
    end else if (cfg_valid && cfg_open) begin
      len_beats <= LEN_W'(cfg_len / BUS_NUM);
      k_shift   <= cfg_k_shift;
      out_shift <= cfg_out_shift;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase    <= PH_LOAD;
      beat_cnt <= '0;
      out_cnt  <= '0;
      rd_addr  <= '0;
      rd_done  <= 1'b0;
      start    <= 1'b0;
    end else begin
      // Sum register holds the final beat one cycle after vec_done
      start <= vec_done;
      case (phase)
        PH_LOAD: begin
          if (vec_done) begin
            beat_cnt <= '0;
            phase    <= PH_COMPUTE;
          end else if (accept) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        PH_COMPUTE: begin
          if (inv_valid) begin
            phase   <= PH_REPLAY;
            rd_addr <= '0;
            rd_done <= 1'b0;
            out_cnt <= '0;
          end
        end
        PH_REPLAY: begin
          if (rd_fire && rd_last) begin
            rd_done <= 1'b1;
          end else if (rd_fire) begin
            rd_addr <= rd_addr + 1'b1;
          end
          // Last output handshake reopens the input
          if (out_fire && out_cnt == last_beat) begin
            phase <= PH_LOAD;
          end else if (out_fire) begin
            out_cnt <= out_cnt + 1'b1;
          end
        end
        default: phase <= PH_LOAD;
      endcase
    end
  end

endmodule

// ==== logic/rms_norm_pkg.sv ====
/*
 * Shared lane count, widths and element types for the RMS-norm engine
 */
package rms_norm_pkg;

  // Lanes per beat and buffer depth in beats
  localparam int BUS_NUM   = 4;
  localparam int MAX_BEATS = 16;

  // Element count, up to 64 elements per vector
  localparam int LEN_W = 7;

  // 64 squares of -128 add up to 2^20
  localparam int SUM_W  = 21;
  localparam int ROOT_W = 11;

  // Reciprocal root with 12 fraction bits, 2^12 / 1 still fits
  localparam int RECIP_FRAC = 12;
  localparam int INV_W      = 13;

  // One lane element, used for data, gamma and output
  typedef logic signed [7:0] elem_t;

  // One beat of BUS_NUM elements
  typedef elem_t [BUS_NUM-1:0] lanes_t;

  // Arithmetic shift amount
  typedef logic [4:0] shift_t;

endpackage

// ==== logic/square_sum_acc.sv ====
/*
 * Sum of squares accumulator. Adds the lane squares of every accepted beat
 * and clears once the total has been handed to the root unit
 */
module square_sum_acc (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           accept,
  input  rms_norm_pkg::lanes_t           in_data,
  input  logic                           clear,
  output logic [rms_norm_pkg::SUM_W-1:0] sum
);

  import rms_norm_pkg::*;

  logic signed [15:0] lane_sq [BUS_NUM];
  logic [SUM_W-1:0]   beat_sq;

  // Squares are never negative, sign extension is harmless
  always_comb begin
    beat_sq = '0;
    for (int i = 0; i < BUS_NUM; i++) begin
      lane_sq[i] = in_data[i] * in_data[i];
      beat_sq    = beat_sq + SUM_W'(lane_sq[i]);
    end
  end

  // Clear and accept never meet, input is closed while the root runs
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum <= '0;
    end else if (clear) begin
      sum <= '0;
    end else if (accept) begin
      sum <= sum + beat_sq;
    end
  end

endmodule

// ==== logic/vector_buffer.sv ====
/*
 * Beat store for one vector. Keeps data and gamma side by side and
 * replays them in order through a registered valid/ready slot
 */
module vector_buffer #(
  parameter int BUS_NUM = rms_norm_pkg::BUS_NUM
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       accept,
  input  rms_norm_pkg::elem_t [BUS_NUM-1:0]          in_data,
  input  rms_norm_pkg::elem_t [BUS_NUM-1:0]          in_gamma,
  input  logic                                       rd_en,
  input  logic [$clog2(rms_norm_pkg::MAX_BEATS)-1:0] rd_addr,
  input  logic                                       rd_last,
  input  logic                                       pipe_ready,
  output logic                                       rd_valid,
  output rms_norm_pkg::elem_t [BUS_NUM-1:0]          x_beat,
  output rms_norm_pkg::elem_t [BUS_NUM-1:0]          gamma_beat,
  output logic                                       beat_last,
  output logic                                       rd_fire
);

  import rms_norm_pkg::*;

  localparam int ADDR_W = $clog2(MAX_BEATS);

  typedef struct packed {
    elem_t [BUS_NUM-1:0] gamma;
    elem_t [BUS_NUM-1:0] x;
  } entry_t;

  entry_t            mem [MAX_BEATS];
  entry_t            rd_entry;
  logic [ADDR_W-1:0] wr_ptr;

  // Write pointer rewinds once the final beat has gone out for replay
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (rd_fire && rd_last) begin
      wr_ptr <= '0;
    end else if (accept) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mem[wr_ptr] <= '{gamma: in_gamma, x: in_data};
    end
  end

  // Read slot refills when empty or being taken by the pipe
  assign rd_fire = rd_en && (!rd_valid || pipe_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid  <= 1'b0;
      beat_last <= 1'b0;
    end else if (rd_fire) begin
      rd_valid  <= 1'b1;
      beat_last <= rd_last;
    end else if (pipe_ready) begin
      rd_valid  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rd_entry <= mem[rd_addr];
    end
  end

  assign x_beat     = rd_entry.x;
  assign gamma_beat = rd_entry.gamma;

endmodule

// ==== rms_norm.f ====
logic/rms_norm_pkg.sv
logic/square_sum_acc.sv
logic/vector_buffer.sv
logic/inv_rms_unit.sv
logic/norm_scale_pipe.sv
logic/rms_norm_ctrl.sv
logic/rms_norm.sv
+incdir+tests
tests/rms_norm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the RMS-norm testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module rms_norm_tb -f rms_norm.f -o rms_norm_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/rms_norm_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1

// ==== tests/rms_norm_tests.svh ====
/*
 * Directed tests for the RMS-norm engine with one task per behavior
 */

task automatic check_value(input string name, input string what,
                           input logic signed [31:0] expected,
                           input logic signed [31:0] actual);
  n_checks++;
  assert (actual === expected) else begin
    n_errors++;
    $display("Error: %s %s expected %0d actual %0d", name, what, expected, actual);
  end
endtask

// -----------------------------------------------------------------------------
// Bus drivers and output collection
// -----------------------------------------------------------------------------
task automatic apply_config(input int len, input int k_sh, input int o_sh);
  while (!in_ready) begin
    @(posedge clk);
    #DRIVE_DELAY;
  end
  cfg_valid     = 1'b1;
  cfg_len       = LEN_W'(len);
  cfg_k_shift   = shift_t'(k_sh);
  cfg_out_shift = shift_t'(o_sh);
  @(posedge clk);
  #DRIVE_DELAY;
  cfg_valid = 1'b0;
endtask

// With poke set, a stray config rides along with the second beat
task automatic send_beats(input int len, input bit poke);
  int nbeats;
  bit taken;
  nbeats = len / BUS_NUM;
  for (int b = 0; b < nbeats; b++) begin
    in_valid = 1'b1;
    for (int l = 0; l < BUS_NUM; l++) begin
      in_data[l]  = vec_x[b * BUS_NUM + l];
      in_gamma[l] = vec_g[b * BUS_NUM + l];
    end
    if (poke && b == 1) begin
      cfg_valid     = 1'b1;
      cfg_len       = LEN_W'(4);
      cfg_k_shift   = shift_t'(0);
      cfg_out_shift = shift_t'(2);
    end
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #DRIVE_DELAY;
      cfg_valid = 1'b0;
    end
  end
  in_valid = 1'b0;
  @(negedge clk);
  assert (!in_ready) else begin
    n_errors++;
    $display("Error: in_ready stayed high after the final input beat");
  end
  @(posedge clk);
  #DRIVE_DELAY;
endtask

task automatic collect_beats(input string name, input int len, input bit bp);
  int nbeats;
  int got;
  int idx;
  nbeats    = len / BUS_NUM;
  got       = 0;
  out_ready = bp ? lfsr_bit() : 1'b1;
  while (got < nbeats) begin
    @(negedge clk);
    assert (!in_ready) else begin
      n_errors++;
      $display("Error: %s in_ready rose before the last output handshake", name);
    end
    if (out_valid && out_ready) begin
      for (int l = 0; l < BUS_NUM; l++) begin
        idx = got * BUS_NUM + l;
        check_value(name, $sformatf("element %0d", idx), exp_y[idx], out_data[l]);
      end
      check_value(name, $sformatf("out_last of beat %0d", got), got == nbeats - 1, out_last);
      got++;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    out_ready = bp ? lfsr_bit() : 1'b1;
  end
  out_ready = 1'b1;
  @(negedge clk);
  assert (in_ready) else begin
    n_errors++;
    $display("Error: %s input did not reopen after the last output beat", name);
  end
  assert (!out_valid) else begin
    n_errors++;
    $display("Error: %s an extra output beat appeared after out_last", name);
  end
  @(posedge clk);
  #DRIVE_DELAY;
endtask

task automatic run_vector(input string name, input int len, input int k_sh,
                          input int o_sh, input bit bp, input bit poke);
  compute_expected(len, k_sh, o_sh);
  apply_config(len, k_sh, o_sh);
  send_beats(len, poke);
  collect_beats(name, len, bp);
endtask

task automatic fill_random(input int len);
  for (int i = 0; i < len; i++) begin
    vec_x[i] = elem_t'(rand_bits(8));
    vec_g[i] = elem_t'(rand_bits(8));
  end
endtask

// -----------------------------------------------------------------------------
// Directed tests
// -----------------------------------------------------------------------------
task automatic check_reset_state();
  @(negedge clk);
  check_value("reset_state", "in_ready", 1, in_ready);
  check_value("reset_state", "out_valid", 0, out_valid);
  check_value("reset_state", "out_last", 0, out_last);
  check_value("reset_state", "inv_valid", 0, rms_norm_i.inv_valid);
  @(posedge clk);
  #DRIVE_DELAY;
endtask

// Large even lanes set the RMS and the small odd lanes stay below saturation
task automatic basic_vector();
  for (int i = 0; i < 16; i++) begin
    if (i % 2 == 1) begin
      vec_x[i] = elem_t'((i % 5) - 2);
    end else if (i % 4 == 0) begin
      vec_x[i] = elem_t'(127 - 2 * i);
    end else begin
      vec_x[i] = elem_t'(2 * i - 127);
    end
    vec_g[i] = 8'sd64;
  end
  run_vector("basic_vector", 16, 4, 6, 1'b0, 1'b0);
endtask

// k_shift tracks log2 of the length
task automatic random_lengths();
  int len;
  for (int n = 0; n < 5; n++) begin
    len = 4 << n;
    fill_random(len);
    run_vector("random_lengths", len, n + 2, 12 + int'(rand_bits(1)), 1'b0, 1'b0);
  end
endtask

task automatic saturation();
  for (int i = 0; i < 8; i++) begin
    vec_x[i] = (i % 2 == 0) ? 8'sd127 : -8'sd128;
    vec_g[i] = (i < 4) ? 8'sd127 : -8'sd128;
  end
  run_vector("saturation", 8, 3, 0, 1'b0, 1'b0);
  fill_random(8);
  run_vector("saturation", 8, 3, 2, 1'b0, 1'b0);
endtask

task automatic zero_vector();
  for (int i = 0; i < 8; i++) begin
    vec_x[i] = '0;
    vec_g[i] = elem_t'(rand_bits(8));
  end
  run_vector("zero_vector", 8, 3, 0, 1'b0, 1'b0);
  check_value("zero_vector", "inv_rms", 8191, rms_norm_i.inv_rms);
endtask

task automatic back_pressure();
  fill_random(32);
  run_vector("back_pressure", 32, 5, 12, 1'b1, 1'b0);
  fill_random(64);
  run_vector("back_pressure", 64, 6, 13, 1'b1, 1'b0);
endtask

// Stray config mid-vector must not land but the next one must
task automatic config_in_flight();
  fill_random(16);
  run_vector("config_in_flight", 16, 4, 12, 1'b0, 1'b1);
  fill_random(16);
  run_vector("config_in_flight", 16, 4, 11, 1'b0, 1'b0);
endtask

// ==== tests/rms_norm_tb.sv ====
/*
 * Testbench for the RMS-norm engine. Directed tests checked against a
 * fixed-point reference model, with a watchdog on the run time
 */
module rms_norm_tb;

  import rms_norm_pkg::*;

  localparam int HALF_PERIOD   = 50;
  localparam int CLK_PERIOD    = 2 * HALF_PERIOD;
  localparam int RESET_CYCLES  = 16;
  localparam int DRIVE_DELAY   = 1;
  localparam int MAX_LEN       = MAX_BEATS * BUS_NUM;
  // Beats over all directed tests
  localparam int TOTAL_BEATS   = 73;
  localparam int WATCHDOG_TIME = (TOTAL_BEATS * 200 + RESET_CYCLES) * CLK_PERIOD;
  localparam logic [31:0] LFSR_SEED = 32'h95d40dc1;

  logic             clk;
  logic             rst_n;
  logic             cfg_valid;
  logic [LEN_W-1:0] cfg_len;
  shift_t           cfg_k_shift;
  shift_t           cfg_out_shift;
  logic             in_valid;
  logic             in_ready;
  lanes_t           in_data;
  lanes_t           in_gamma;
  logic             out_valid;
  logic             out_ready;
  lanes_t           out_data;
  logic             out_last;

  // Vector under test and what the model expects back
  elem_t       vec_x [MAX_LEN];
  elem_t       vec_g [MAX_LEN];
  elem_t       exp_y [MAX_LEN];
  int          exp_inv;
  logic [31:0] lfsr_state;
  int          n_checks;
  int          n_errors;

  rms_norm #(.BUS_NUM(BUS_NUM)) rms_norm_i (
    .clk(clk), .rst_n(rst_n),
    .cfg_valid(cfg_valid), .cfg_len(cfg_len),
    .cfg_k_shift(cfg_k_shift), .cfg_out_shift(cfg_out_shift),
    .in_valid(in_valid), .in_ready(in_ready),
    .in_data(in_data), .in_gamma(in_gamma),
    .out_valid(out_valid), .out_ready(out_ready),
    .out_data(out_data), .out_last(out_last)
  );

  always #HALF_PERIOD clk = ~clk;

  // ---------------------------------------------------------------------------
  // Stimulus source, taps 32 22 2 1
  // ---------------------------------------------------------------------------
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  function automatic int floor_sqrt(input int v);
    int r;
    r = 0;
    while ((r + 1) * (r + 1) <= v) begin
      r++;
    end
    return r;
  endfunction

  // 2^12 over the root, zero root pinned at the 13-bit maximum
  function automatic int recip_root(input int root);
    if (root == 0) begin
      return 8191;
    end
    return (4096 / root > 8191) ? 8191 : 4096 / root;
  endfunction

  task automatic compute_expected(input int len, input int k_sh, input int o_sh);
    int     sum;
    longint p;
    sum = 0;
    for (int i = 0; i < len; i++) begin
      sum += int'(vec_x[i]) * int'(vec_x[i]);
    end
    exp_inv = recip_root(floor_sqrt(sum >> k_sh));
    for (int i = 0; i < len; i++) begin
      p = longint'(vec_x[i]) * longint'(vec_g[i]) * longint'(exp_inv);
      p = p >>> o_sh;
      if (p > 127) begin
        exp_y[i] = 8'sd127;
      end else if (p < -128) begin
        exp_y[i] = -8'sd128;
      end else begin
        exp_y[i] = elem_t'(p);
      end
    end
  endtask

  `include "rms_norm_tests.svh"

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    lfsr_state    = LFSR_SEED;
    n_checks      = 0;
    n_errors      = 0;
    cfg_valid     = 1'b0;
    cfg_len       = '0;
    cfg_k_shift   = '0;
    cfg_out_shift = '0;
    in_valid      = 1'b0;
    in_data       = '0;
    in_gamma      = '0;
    out_ready     = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    check_reset_state();
    basic_vector();
    random_lengths();
    saturation();
    zero_vector();
    back_pressure();
    config_in_flight();

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin
    #(WATCHDOG_TIME);
    $display("Error: watchdog expired before the tests completed");
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    $display(">>> FAIL");
    $finish;
  end

endmodule
